// ==== Makefile ====
# Verilator build and run of the planar video testbench

VERILATOR ?= verilator
TOP       ?= tb_vga_planar
BUILD     ?= obj_dir
LOG       ?= sim.log
FLIST     ?= src.f
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== rtl/vga_attr_palette.sv ====
// Attribute stage masking planes, looking up the palette and registering the pixel
module vga_attr_palette (
  input  logic                clk,
  input  logic                rst,
  input  logic [3:0]          attr_i,
  input  logic                hsync_i,
  input  logic                vsync_i,
  input  logic                de_i,
  input  vga_bus_pkg::ctrl_t  ctrl_i,
  output vga_bus_pkg::pixel_t pixel_o
);

  logic [3:0]  pal_idx;
  logic [11:0] pal_rgb;

  // Disabled planes drop out of the index
  assign pal_idx = attr_i & ctrl_i.plane_en;
  assign pal_rgb = ctrl_i.palette[pal_idx];

  always_ff @(posedge clk)
  begin
    // Syncs carry the idle level from upstream through reset
    pixel_o.hsync <= hsync_i;
    pixel_o.vsync <= vsync_i;
    if (rst)
    begin
      pixel_o.rgb <= '0;
      pixel_o.de  <= 1'b0;
    end
    else
    begin
      // Black outside the visible area
      pixel_o.rgb <= de_i ? pal_rgb : 12'd0;
      pixel_o.de  <= de_i;
    end
  end

endmodule

// ==== rtl/vga_bus_pkg.sv ====
// Bus package with the Wishbone, memory, control, raster and pixel structs and decoder enums
package vga_bus_pkg;

  // Wishbone classic master request
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [17:0] adr;
    logic [15:0] dat;
  } wb_req_t;

  // Wishbone slave response
  typedef struct packed {
    logic        ack;
    logic [15:0] dat;
  } wb_rsp_t;

  // Host side plane memory access
  typedef struct packed {
    logic        en;
    logic        we;
    logic [1:0]  plane;
    logic [14:0] offset;
    logic [15:0] data;
  } mem_req_t;

  // Plane enable mask and 16 entry RGB444 palette
  typedef struct packed {
    logic [3:0]        plane_en;
    logic [15:0][11:0] palette;
  } ctrl_t;

  // Raster position with syncs and display enable
  typedef struct packed {
    logic [9:0] h_count;
    logic [9:0] v_count;
    logic       hsync;
    logic       vsync;
    logic       de;
  } raster_t;

  // Final pixel towards the display
  typedef struct packed {
    logic [11:0] rgb;
    logic        hsync;
    logic        vsync;
    logic        de;
  } pixel_t;

  typedef enum logic {
    DEC_IDLE,
    DEC_ACK
  } dec_state_e;

  typedef enum logic [1:0] {
    OP_MEM_WR,
    OP_MEM_RD,
    OP_REG_WR,
    OP_REG_RD
  } wb_op_e;

endpackage

// ==== rtl/vga_cfg_pkg.sv ====
// Video configuration package holding raster timing, plane geometry and register indices
package vga_cfg_pkg;

  // Horizontal timing in pixel clocks
  localparam logic [9:0] H_VISIBLE = 10'd640;
  localparam logic [9:0] H_FRONT   = 10'd16;
  localparam logic [9:0] H_SYNC    = 10'd96;
  localparam logic [9:0] H_BACK    = 10'd48;

  // Vertical timing in lines
  localparam logic [9:0] V_VISIBLE = 10'd480;
  localparam logic [9:0] V_FRONT   = 10'd10;
  localparam logic [9:0] V_SYNC    = 10'd2;
  localparam logic [9:0] V_BACK    = 10'd33;

  // Four bit planes, 40 words of 16 pixels per line
  localparam int NUM_PLANES     = 4;
  localparam int WORDS_PER_LINE = 40;

  // Raster to attribute latency of the planar fetch
  localparam int FETCH_DELAY = 10;

  // Control register indices
  typedef enum logic [3:0] {
    REG_PLANE_EN = 4'd0,
    REG_PAL_BASE = 4'd8
  } reg_idx_e;

endpackage

// ==== rtl/vga_crtc.sv ====
// CRT timing generator producing 800x525 raster counters, syncs and display enable
module vga_crtc #(
  parameter bit SYNC_ACTIVE_LOW = 1'b1
) (
  input  logic                  clk,
  input  logic                  rst,
  output vga_bus_pkg::raster_t  raster_o
);

  localparam logic [9:0] H_TOTAL = vga_cfg_pkg::H_VISIBLE + vga_cfg_pkg::H_FRONT
                                 + vga_cfg_pkg::H_SYNC + vga_cfg_pkg::H_BACK;
  localparam logic [9:0] V_TOTAL = vga_cfg_pkg::V_VISIBLE + vga_cfg_pkg::V_FRONT
                                 + vga_cfg_pkg::V_SYNC + vga_cfg_pkg::V_BACK;
  localparam logic [9:0] HS_START = vga_cfg_pkg::H_VISIBLE + vga_cfg_pkg::H_FRONT;
  localparam logic [9:0] HS_END   = HS_START + vga_cfg_pkg::H_SYNC;
  localparam logic [9:0] VS_START = vga_cfg_pkg::V_VISIBLE + vga_cfg_pkg::V_FRONT;
  localparam logic [9:0] VS_END   = VS_START + vga_cfg_pkg::V_SYNC;

  logic [9:0] h_cnt;
  logic [9:0] v_cnt;
  logic       hs_act;
  logic       vs_act;

  // Sync windows, active high internally
  assign hs_act = (h_cnt >= HS_START) && (h_cnt < HS_END);
  assign vs_act = (v_cnt >= VS_START) && (v_cnt < VS_END);

  // Free running counters, line wrap steps the line counter
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      h_cnt <= '0;
      v_cnt <= '0;
    end
    else if (h_cnt == H_TOTAL - 10'd1)
    begin
      h_cnt <= '0;
      v_cnt <= (v_cnt == V_TOTAL - 10'd1) ? 10'd0 : v_cnt + 10'd1;
    end
    else
    begin
      h_cnt <= h_cnt + 10'd1;
    end
  end

  // Registered raster, reset shows the last position so 0,0 follows cleanly
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      raster_o.h_count <= H_TOTAL - 10'd1;
      raster_o.v_count <= V_TOTAL - 10'd1;
      raster_o.hsync   <= SYNC_ACTIVE_LOW;
      raster_o.vsync   <= SYNC_ACTIVE_LOW;
      raster_o.de      <= 1'b0;
    end
    else
    begin
      raster_o.h_count <= h_cnt;
      raster_o.v_count <= v_cnt;
      raster_o.hsync   <= hs_act ^ SYNC_ACTIVE_LOW;
      raster_o.vsync   <= vs_act ^ SYNC_ACTIVE_LOW;
      raster_o.de      <= (h_cnt < vga_cfg_pkg::H_VISIBLE) && (v_cnt < vga_cfg_pkg::V_VISIBLE);
    end
  end

endmodule

// ==== rtl/vga_planar_fetch.sv ====
// Planar fetch reading four plane words per 16-pixel group and shifting out 4-bit attributes
module vga_planar_fetch (
  input  logic                 clk,
  input  logic                 rst,
  input  vga_bus_pkg::raster_t raster_i,
  output logic [16:0]          mem_adr_o,
  output logic                 mem_stb_o,
  input  logic [15:0]          mem_dat_i,
  output logic [3:0]           attr_o,
  output logic                 hsync_o,
  output logic                 vsync_o,
  output logic                 de_o
);

  localparam int NP  = vga_cfg_pkg::NUM_PLANES;
  localparam int DLY = vga_cfg_pkg::FETCH_DELAY;
  // Load stage leaves one cycle for the mask and one for attr_o
  localparam int LOAD     = DLY - 3;
  localparam int RD_FIRST = LOAD - NP;

  logic [LOAD:0]   pipe;
  logic [14:0]     row_base;
  logic [5:0]      col;
  logic [14:0]     word_offset;
  logic [1:0]      plane_sel;
  logic [15:0]     plane_tmp [NP-1];
  logic [15:0]     plane_q [NP];
  logic [15:0]     bit_mask;
  logic [NP-1:0]   pix_bits;
  logic [DLY-1:0]  hs_dly;
  logic [DLY-1:0]  vs_dly;
  logic [DLY-1:0]  de_dly;

  // One-hot group start, a new group every 16 pixels
  always_ff @(posedge clk)
  begin
    if (rst)
      pipe <= '0;
    else
      pipe <= {pipe[LOAD-1:0], raster_i.h_count[3:0] == 4'd0};
  end

  // Word offset v*40 + h/16, constant across a group
  always_ff @(posedge clk)
  begin
    row_base    <= 15'(raster_i.v_count * vga_cfg_pkg::WORDS_PER_LINE);
    col         <= raster_i.h_count[9:4];
    word_offset <= row_base + 15'(col);
  end

  // Plane number from the read slot
  always_comb
  begin
    plane_sel = '0;
    for (int p = 0; p < NP; p++)
    begin
      if (pipe[RD_FIRST + p])
        plane_sel = 2'(p);
    end
  end

  assign mem_adr_o = {plane_sel, word_offset};
  assign mem_stb_o = |pipe[RD_FIRST +: NP];

  // Capture planes 0 to 2, plane 3 goes straight into the shifter
  always_ff @(posedge clk)
  begin
    for (int p = 0; p < NP - 1; p++)
    begin
      if (pipe[RD_FIRST + 1 + p])
        plane_tmp[p] <= mem_dat_i;
    end
    if (pipe[LOAD])
    begin
      for (int p = 0; p < NP - 1; p++)
        plane_q[p] <= plane_tmp[p];
      plane_q[NP-1] <= mem_dat_i;
    end
  end

  // Walking bit, MSB pixel first
  always_ff @(posedge clk)
  begin
    if (rst)
      bit_mask <= '0;
    else
      bit_mask <= {pipe[LOAD], bit_mask[15:1]};
  end

  always_comb
  begin
    for (int p = 0; p < NP; p++)
      pix_bits[p] = |(plane_q[p] & bit_mask);
  end

  always_ff @(posedge clk)
    attr_o <= pix_bits;

  // Sync and de delay lines
  // reset fills with the incoming level so idle polarity carries through
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      hs_dly <= {DLY{raster_i.hsync}};
      vs_dly <= {DLY{raster_i.vsync}};
      de_dly <= '0;
    end
    else
    begin
      hs_dly <= {hs_dly[DLY-2:0], raster_i.hsync};
      vs_dly <= {vs_dly[DLY-2:0], raster_i.vsync};
      de_dly <= {de_dly[DLY-2:0], raster_i.de};
    end
  end

  assign hsync_o = hs_dly[DLY-1];
  assign vsync_o = vs_dly[DLY-1];
  assign de_o    = de_dly[DLY-1];

endmodule

// ==== rtl/vga_planar_top.sv ====
// Planar 16-colour 640x480 video subsystem connecting decoder, memory, CRTC, fetch and palette
module vga_planar_top #(
  parameter int MEM_WORDS       = 19200,
  parameter bit SYNC_ACTIVE_LOW = 1'b1
) (
  input  logic                 clk,
  input  logic                 rst,
  input  vga_bus_pkg::wb_req_t wb_req_i,
  output vga_bus_pkg::wb_rsp_t wb_rsp_o,
  output vga_bus_pkg::pixel_t  pixel_o
);

  vga_bus_pkg::raster_t  raster;
  vga_bus_pkg::mem_req_t host_req;
  vga_bus_pkg::ctrl_t    ctrl;
  logic [15:0]           host_rdata;
  logic [16:0]           disp_adr;
  logic                  disp_stb;
  logic [15:0]           disp_rdata;
  logic [3:0]            attr;
  logic                  attr_hsync;
  logic                  attr_vsync;
  logic                  attr_de;

  vga_crtc #(.SYNC_ACTIVE_LOW(SYNC_ACTIVE_LOW)) u_crtc (
    .clk      (clk),
    .rst      (rst),
    .raster_o (raster)
  );

  vga_reg_decode #(.MEM_WORDS(MEM_WORDS)) u_decode (
    .clk         (clk),
    .rst         (rst),
    .wb_req_i    (wb_req_i),
    .wb_rsp_o    (wb_rsp_o),
    .mem_req_o   (host_req),
    .mem_rdata_i (host_rdata),
    .ctrl_o      (ctrl)
  );

  vga_plane_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (
    .clk          (clk),
    .host_req_i   (host_req),
    .host_rdata_o (host_rdata),
    .disp_adr_i   (disp_adr),
    .disp_stb_i   (disp_stb),
    .disp_rdata_o (disp_rdata)
  );

  // Execute stage
  vga_planar_fetch u_fetch (
    .clk       (clk),
    .rst       (rst),
    .raster_i  (raster),
    .mem_adr_o (disp_adr),
    .mem_stb_o (disp_stb),
    .mem_dat_i (disp_rdata),
    .attr_o    (attr),
    .hsync_o   (attr_hsync),
    .vsync_o   (attr_vsync),
    .de_o      (attr_de)
  );

  // Result stage
  vga_attr_palette u_palette (
    .clk     (clk),
    .rst     (rst),
    .attr_i  (attr),
    .hsync_i (attr_hsync),
    .vsync_i (attr_vsync),
    .de_i    (attr_de),
    .ctrl_i  (ctrl),
    .pixel_o (pixel_o)
  );

endmodule

// ==== rtl/vga_plane_mem.sv ====
// Four-plane dual-port video memory with host read/write and display read ports
module vga_plane_mem #(
  parameter int MEM_WORDS = 19200
) (
  input  logic                  clk,
  input  vga_bus_pkg::mem_req_t host_req_i,
  output logic [15:0]           host_rdata_o,
  input  logic [16:0]           disp_adr_i,
  input  logic                  disp_stb_i,
  output logic [15:0]           disp_rdata_o
);

  logic [15:0] mem [vga_cfg_pkg::NUM_PLANES][MEM_WORDS];
  logic        host_in_range;
  logic        disp_in_range;

  // Offsets past the plane depth are not backed by storage
  assign host_in_range = 32'(host_req_i.offset) < MEM_WORDS;
  assign disp_in_range = 32'(disp_adr_i[14:0]) < MEM_WORDS;

  // Host port, read before write
  always_ff @(posedge clk)
  begin
    if (host_req_i.en)
    begin
      if (host_req_i.we && host_in_range)
        mem[host_req_i.plane][host_req_i.offset] <= host_req_i.data;
      host_rdata_o <= host_in_range ? mem[host_req_i.plane][host_req_i.offset] : 16'd0;
    end
  end

  // Display port, read only
  always_ff @(posedge clk)
  begin
    if (disp_stb_i)
      disp_rdata_o <= disp_in_range ? mem[disp_adr_i[16:15]][disp_adr_i[14:0]] : 16'd0;
  end

endmodule

// ==== rtl/vga_reg_decode.sv ====
// Wishbone classic slave decoding host cycles into plane memory and control register accesses
module vga_reg_decode #(
  parameter int MEM_WORDS = 19200
) (
  input  logic                  clk,
  input  logic                  rst,
  input  vga_bus_pkg::wb_req_t  wb_req_i,
  output vga_bus_pkg::wb_rsp_t  wb_rsp_o,
  output vga_bus_pkg::mem_req_t mem_req_o,
  input  logic [15:0]           mem_rdata_i,
  output vga_bus_pkg::ctrl_t    ctrl_o
);

  localparam logic [4:0] IDX_PLANE_EN = 5'(vga_cfg_pkg::REG_PLANE_EN);
  localparam logic [4:0] IDX_PAL_BASE = 5'(vga_cfg_pkg::REG_PAL_BASE);

  vga_bus_pkg::dec_state_e state_q;
  vga_bus_pkg::wb_op_e     op;
  vga_bus_pkg::wb_op_e     op_q;
  logic                    req_valid;
  logic                    mem_hit;
  logic                    pal_hit;
  logic [4:0]              reg_idx;
  logic [3:0]              pal_sel;
  logic [15:0]             reg_rdata;
  logic [15:0]             reg_rdata_q;

  // New cycle only taken in idle
  assign req_valid = wb_req_i.cyc && wb_req_i.stb && (state_q == vga_bus_pkg::DEC_IDLE);
  // Memory space with offset inside the plane depth
  assign mem_hit   = !wb_req_i.adr[17] && (32'(wb_req_i.adr[14:0]) < MEM_WORDS);
  assign reg_idx   = wb_req_i.adr[4:0];
  assign pal_hit   = (reg_idx >= IDX_PAL_BASE) && (reg_idx < IDX_PAL_BASE + 5'd16);
  assign pal_sel   = 4'(reg_idx - IDX_PAL_BASE);

  // Out of range memory falls through to the register ops, reads zero
  always_comb
  begin
    if (mem_hit)
      op = wb_req_i.we ? vga_bus_pkg::OP_MEM_WR : vga_bus_pkg::OP_MEM_RD;
    else
      op = wb_req_i.we ? vga_bus_pkg::OP_REG_WR : vga_bus_pkg::OP_REG_RD;
  end

  // Register read mux, unmapped indices give zero
  always_comb
  begin
    reg_rdata = '0;
    if (wb_req_i.adr[17])
    begin
      if (reg_idx == IDX_PLANE_EN)
        reg_rdata = {12'd0, ctrl_o.plane_en};
      else if (pal_hit)
        reg_rdata = {4'd0, ctrl_o.palette[pal_sel]};
    end
  end

  // Memory access issued in the accept cycle, data returns with ack
  always_comb
  begin
    mem_req_o.en     = req_valid && mem_hit;
    mem_req_o.we     = (op == vga_bus_pkg::OP_MEM_WR);
    mem_req_o.plane  = wb_req_i.adr[16:15];
    mem_req_o.offset = wb_req_i.adr[14:0];
    mem_req_o.data   = wb_req_i.dat;
  end

  // Handshake FSM and control register writes
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= vga_bus_pkg::DEC_IDLE;
      ctrl_o  <= '0;
    end
    else
    begin
      case (state_q)
        vga_bus_pkg::DEC_IDLE: if (req_valid) state_q <= vga_bus_pkg::DEC_ACK;
        default:               state_q <= vga_bus_pkg::DEC_IDLE;
      endcase
      if (req_valid && (op == vga_bus_pkg::OP_REG_WR) && wb_req_i.adr[17])
      begin
        if (reg_idx == IDX_PLANE_EN)
          ctrl_o.plane_en <= wb_req_i.dat[3:0];
        else if (pal_hit)
          ctrl_o.palette[pal_sel] <= wb_req_i.dat[11:0];
      end
    end
  end

  // Op and register data held for the ack cycle
  always_ff @(posedge clk)
  begin
    if (req_valid)
    begin
      op_q        <= op;
      reg_rdata_q <= reg_rdata;
    end
  end

  assign wb_rsp_o.ack = (state_q == vga_bus_pkg::DEC_ACK);
  assign wb_rsp_o.dat = (op_q == vga_bus_pkg::OP_MEM_RD) ? mem_rdata_i : reg_rdata_q;

endmodule

// ==== src.f ====
rtl/vga_cfg_pkg.sv
rtl/vga_bus_pkg.sv
rtl/vga_crtc.sv
rtl/vga_reg_decode.sv
rtl/vga_plane_mem.sv
rtl/vga_planar_fetch.sv
rtl/vga_attr_palette.sv
rtl/vga_planar_top.sv
verif/vga_clkgen.sv
verif/vga_planar_properties.sv
verif/tb_vga_planar.sv

// ==== verif/tb_vga_planar.sv ====
// Testbench for the planar video pipeline, driven from a command file with model based checks
module tb_vga_planar;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int     MEM_WORDS       = 19200;
  localparam bit     SYNC_ACTIVE_LOW = 1'b1;
  localparam longint FRAME_CYCLES    = 420000;
  localparam longint CLK_NS          = 20;

  logic                 clk;
  logic                 rst;
  vga_bus_pkg::wb_req_t wb_req;
  vga_bus_pkg::wb_rsp_t wb_rsp;
  vga_bus_pkg::pixel_t  pixel;

  // Reference model of planes and control registers
  logic [15:0] model_mem [4][MEM_WORDS];
  bit          written [4][MEM_WORDS];
  logic [3:0]  plane_en_m;
  logic [11:0] pal_m [16];

  // Commands read from the data file
  byte         ops [$];
  logic [31:0] arg_a [$];
  logic [31:0] arg_b [$];
  logic [31:0] arg_c [$];

  logic [31:0] lfsr;
  int          errors;
  longint      limit_ns;

  vga_clkgen u_clkgen (
    .clk_o (clk),
    .rst_o (rst)
  );

  vga_planar_top #(
    .MEM_WORDS       (MEM_WORDS),
    .SYNC_ACTIVE_LOW (SYNC_ACTIVE_LOW)
  ) u_dut (
    .clk      (clk),
    .rst      (rst),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp),
    .pixel_o  (pixel)
  );

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One step per bit taken
  function logic [15:0] random_word();
    logic [15:0] w;
    w = '0;
    for (int i = 0; i < 16; i++)
    begin
      lfsr = lfsr_step(lfsr);
      w = {w[14:0], lfsr[0]};
    end
    return w;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("Mismatch at %0t ns: %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  // One Wishbone classic cycle, driven on falling edges
  task automatic bus_cycle(input logic we, input logic [17:0] adr, input logic [15:0] dat,
                           output logic [15:0] rdata);
    int wait_cnt;
    wait_cnt = 0;
    @(negedge clk);
    wb_req = '{1'b1, 1'b1, we, adr, dat};
    do
    begin
      @(negedge clk);
      wait_cnt++;
    end
    while (!wb_rsp.ack && wait_cnt < 16);
    assert (wb_rsp.ack)
    else
    begin
      $display("No ack for the bus cycle to address %h at %0t ns", adr, $time);
      errors++;
    end
    rdata = wb_rsp.dat;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    @(negedge clk);
    assert (!wb_rsp.ack)
    else
    begin
      $display("Ack still high one cycle after the bus cycle to %h at %0t ns", adr, $time);
      errors++;
    end
  endtask

  task automatic mem_write(input logic [1:0] plane, input logic [14:0] off, input logic [15:0] d);
    logic [15:0] unused;
    bus_cycle(1'b1, {1'b0, plane, off}, d, unused);
    if (off < MEM_WORDS)
    begin
      model_mem[plane][off] = d;
      written[plane][off] = 1'b1;
    end
  endtask

  // Model follows the register map
  task automatic reg_write(input logic [4:0] idx, input logic [15:0] d);
    logic [15:0] unused;
    bus_cycle(1'b1, {1'b1, 12'd0, idx}, d, unused);
    if (idx == 5'd0)
      plane_en_m = d[3:0];
    else if (idx >= 5'd8 && idx < 5'd24)
      pal_m[idx - 5'd8] = d[11:0];
  endtask

  // One visible frame, starting at the next vsync
  task automatic check_frame();
    int          cnt;
    int          hs_cnt;
    int          off;
    logic [3:0]  idx;
    do @(negedge clk); while (pixel.vsync ^ SYNC_ACTIVE_LOW);
    do @(negedge clk); while (!(pixel.vsync ^ SYNC_ACTIVE_LOW));
    cnt = 0;
    while (pixel.vsync ^ SYNC_ACTIVE_LOW)
    begin
      cnt++;
      @(negedge clk);
    end
    check_eq("vsync active cycles", 32'd1600, cnt);
    while (!pixel.de)
    begin
      check_eq("pixel_o.rgb in blank", 32'd0, pixel.rgb);
      @(negedge clk);
    end
    for (int y = 0; y < 480; y++)
    begin
      for (int x = 0; x < 640; x++)
      begin
        assert (pixel.de)
        else
        begin
          $display("de dropped early on line %0d at pixel %0d", y, x);
          errors++;
        end
        off = y * 40 + x / 16;
        // Only words the model knows are compared
        if (written[0][off] && written[1][off] && written[2][off] && written[3][off])
        begin
          for (int p = 0; p < 4; p++)
            idx[p] = model_mem[p][off][15 - x % 16];
          idx = idx & plane_en_m;
          check_eq("pixel_o.rgb", {20'd0, pal_m[idx]}, {20'd0, pixel.rgb});
        end
        @(negedge clk);
      end
      cnt = 0;
      hs_cnt = 0;
      // Horizontal blank, last line ends the frame
      while (!pixel.de && y < 479)
      begin
        check_eq("pixel_o.rgb in blank", 32'd0, pixel.rgb);
        if (pixel.hsync ^ SYNC_ACTIVE_LOW)
          hs_cnt++;
        cnt++;
        @(negedge clk);
      end
      if (y < 479)
      begin
        check_eq("de low cycles per line", 32'd160, cnt);
        check_eq("hsync active cycles", 32'd96, hs_cnt);
      end
    end
    check_eq("pixel_o.de after last line", 32'd0, pixel.de);
  endtask

  // Load the whole command file before the run
  task automatic read_commands();
    int          fd;
    int          n;
    string       line;
    byte         op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    fd = $fopen("verif/vga_planar_input.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open the stimulus file verif/vga_planar_input.txt");
      errors++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        n = $fgets(line, fd);
        if (n > 1 && line[0] != "#")
        begin
          a = 0;
          b = 0;
          c = 0;
          n = $sscanf(line, "%c %h %h %h", op, a, b, c);
          ops.push_back(op);
          arg_a.push_back(a);
          arg_b.push_back(b);
          arg_c.push_back(c);
        end
      end
      $fclose(fd);
    end
  endtask

  // Watchdog, sync search can cost up to one extra frame per frame command
  initial
  begin
    wait (limit_ns > 0);
    #(limit_ns);
    $display("Watchdog expired after %0d ns", limit_ns);
    $display("tests failed");
    $finish;
  end

  initial
  begin
    longint      cycles;
    logic [15:0] rdata;
    wb_req = '0;
    errors = 0;
    lfsr = 32'h45ac_836e;
    plane_en_m = '0;
    limit_ns = 0;
    for (int i = 0; i < 16; i++)
      pal_m[i] = '0;
    read_commands();
    cycles = 1000;
    foreach (ops[i])
    begin
      if (ops[i] == "F")
        cycles += 2 * FRAME_CYCLES;
      else if (ops[i] == "L")
        cycles += 64 * arg_a[i];
      else
        cycles += 16;
    end
    limit_ns = cycles * CLK_NS;
    while (rst)
      @(negedge clk);
    foreach (ops[i])
    begin
      case (ops[i])
        "W": mem_write(arg_a[i][1:0], arg_b[i][14:0], arg_c[i][15:0]);
        "R":
        begin
          bus_cycle(1'b0, {1'b0, arg_a[i][1:0], arg_b[i][14:0]}, 16'd0, rdata);
          check_eq("wb_rsp_o.dat memory read", arg_c[i], {16'd0, rdata});
        end
        "S": reg_write(arg_a[i][4:0], arg_b[i][15:0]);
        "G":
        begin
          bus_cycle(1'b0, {1'b1, 12'd0, arg_a[i][4:0]}, 16'd0, rdata);
          check_eq("wb_rsp_o.dat register read", arg_b[i], {16'd0, rdata});
        end
        "L":
        begin
          for (int off = 0; off < int'(arg_a[i]); off++)
            for (int p = 0; p < 4; p++)
              mem_write(2'(p), 15'(off), random_word());
        end
        "F": check_frame();
        default:
        begin
          $display("Unknown command %c in the stimulus file", ops[i]);
          errors++;
        end
      endcase
    end
    $display("Error count: %0d", errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== verif/vga_clkgen.sv ====
// Testbench clock and reset source, 20 ns period with reset held for 8 cycles
module vga_clkgen (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Reset released on a falling edge after 8 rising edges
  initial
  begin
    rst_o = 1'b1;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

// ==== verif/vga_planar_input.txt ====
# Columns: op a b, hex. W plane offset data, R plane offset expected
# S index data, G index expected, L word count of random fill per plane, F checks one frame
S 0 f
G 0 f
S 8 000
S 9 00a
S a 0a0
S b 0aa
S c a00
S d a0a
S e a50
S f aaa
S 10 555
S 11 55f
S 12 5f5
S 13 5ff
S 14 f55
S 15 f5f
S 16 ff5
S 17 fff
G 9 00a
G 17 fff
S 5 123
G 5 0
L 4b0
W 3 12c 8001
R 3 12c 8001
W 1 4b00 1234
R 1 4b00 0
R 2 7fff 0
W 0 3e80 a5a5
R 0 3e80 a5a5
F
S 0 5
S 9 abc
S d 555
G 0 5
G 9 abc
F

// ==== verif/vga_planar_properties.sv ====
// Concurrent checks on the Wishbone handshake and the output sync shape
module vga_planar_properties #(
  parameter bit SYNC_ACTIVE_LOW = 1'b1
) (
  input logic                 clk,
  input logic                 rst,
  input vga_bus_pkg::wb_req_t wb_req_i,
  input vga_bus_pkg::wb_rsp_t wb_rsp_i,
  input vga_bus_pkg::pixel_t  pixel_i
);
  timeunit 1ns;
  timeprecision 100ps;

  logic hs_active;

  assign hs_active = pixel_i.hsync ^ SYNC_ACTIVE_LOW;

  // Ack only answers a request seen the cycle before
  ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    wb_rsp_i.ack |-> $past(wb_req_i.cyc && wb_req_i.stb))
    else $error("ack raised without a preceding cyc and stb");

  // Single cycle ack
  ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
    wb_rsp_i.ack |=> !wb_rsp_i.ack)
    else $error("ack held high for two cycles");

  // Visible area never overlaps horizontal sync
  de_outside_hsync: assert property (@(posedge clk) disable iff (rst)
    !(pixel_i.de && hs_active))
    else $error("de high during active hsync");

endmodule

bind vga_planar_top vga_planar_properties #(.SYNC_ACTIVE_LOW(SYNC_ACTIVE_LOW)) u_props (
  .clk      (clk),
  .rst      (rst),
  .wb_req_i (wb_req_i),
  .wb_rsp_i (wb_rsp_o),
  .pixel_i  (pixel_o)
);
